/* list.f */
vlsu_pkg.sv
vreg_file.sv
result_fifo.sv
vlsu.sv
vlsu_top.sv
tb_vlsu_top.sv

/* Bender.yml */
package:
  name: vlsu

sources:
  - vlsu_pkg.sv
  - vreg_file.sv
  - result_fifo.sv
  - vlsu.sv
  - vlsu_top.sv
  - target: test
    files:
      - tb_vlsu_top.sv

/* tb_vlsu_top.sv */
/*
 * Testbench for the vector load/store subsystem
 * Clock, reset, memory model with random stalls, reference model and checker
 */

`timescale 1ns/1ps

module tb_vlsu_top;

  import vlsu_pkg::*;

  localparam int          CLK_PERIOD = 10;
  localparam int          N_ROUNDS   = 12;
  // Copy pair plus one load and one store per round
  localparam int          N_INSTR    = 2 + 2 * N_ROUNDS;
  localparam logic [31:0] SEED       = 32'h66f8a6b5;

  logic               clk_i;
  logic               rst_i;
  logic               req_valid_i;
  logic               req_ready_o;
  vlsu_op_e           req_op_i;
  logic [ID_W-1:0]    req_id_i;
  logic [VREG_AW-1:0] req_vd_i;
  logic [ADDR_W-1:0]  req_addr_i;
  logic [VL_W-1:0]    req_vl_i;
  logic               rsp_valid_o;
  logic [ID_W-1:0]    rsp_id_o;
  logic               mem_valid_o;
  logic               mem_ready_i;
  logic [ADDR_W-1:0]  mem_addr_o;
  logic               mem_we_o;
  logic [ELEM_W-1:0]  mem_wdata_o;
  logic               mem_result_valid_i;
  logic [ELEM_W-1:0]  mem_rdata_i;

  // Memory seen by the DUT and the memory the reference model predicts
  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] exp_vrf [NR_VREGS][NR_ELEMS];
  logic [31:0] exp_addr_q [$];
  logic        exp_we_q [$];
  logic [31:0] exp_wdata_q [$];
  logic [31:0] rdata_q [$];
  int          due_q [$];
  string       test_name;
  int          rsp_count;

  vlsu_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Error reporting and reference model
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("MISMATCH test=%s %s expected=0x%08h actual=0x%08h",
             test_name, what, exp_v, act_v);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR test=%s %s", test_name, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // Untouched memory returns a word built from its whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
  endfunction

  // Expected requests, register contents and memory contents of one instruction
  function automatic void predict(input vlsu_op_e op, input logic [2:0] vd,
                                  input logic [31:0] base, input int vl);
    logic [31:0] addr;
    for (int i = 0; i < vl; i++) begin
      addr = base + 32'(4 * i);
      exp_addr_q.push_back(addr);
      exp_we_q.push_back(op == VSE);
      if (op == VLE) begin
        exp_vrf[vd][i] = ref_word(addr);
        exp_wdata_q.push_back(32'h0);
      end else begin
        exp_wdata_q.push_back(exp_vrf[vd][i]);
        ref_mem[addr] = exp_vrf[vd][i];
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : memory_proc
    int cycle;
    int due;
    int last_due;
    if (rst_i) begin
      cycle    = 0;
      last_due = 0;
      due_q.delete();
      rdata_q.delete();
      mem_ready_i        <= 1'b0;
      mem_result_valid_i <= 1'b0;
    end else begin
      cycle = cycle + 1;
      mem_ready_i <= (($urandom % 4) != 0);
      if (mem_valid_o && mem_ready_i) begin
        if (mem_we_o) begin
          model_mem[mem_addr_o] = mem_wdata_o;
        end
        // Results stay in order with at most one per cycle
        due = cycle + 1 + int'($urandom % 5);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        rdata_q.push_back(model_word(mem_addr_o));
      end
      mem_result_valid_i <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        mem_result_valid_i <= 1'b1;
        mem_rdata_i        <= rdata_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : check_proc
    logic        pending;
    logic [3:0]  exp_id;
    logic [31:0] exp_a;
    logic        exp_w;
    logic [31:0] exp_d;
    if (rst_i) begin
      pending   = 1'b0;
      rsp_count = 0;
    end else begin
      if (mem_valid_o && mem_ready_i) begin
        assert (exp_addr_q.size() != 0)
          else report_error("memory request issued beyond the vector length");
        exp_a = exp_addr_q.pop_front();
        exp_w = exp_we_q.pop_front();
        exp_d = exp_wdata_q.pop_front();
        assert (mem_addr_o == exp_a) else report_mismatch("mem_addr", exp_a, mem_addr_o);
        assert (mem_we_o == exp_w) else report_mismatch("mem_we", 32'(exp_w), 32'(mem_we_o));
        if (exp_w) begin
          assert (mem_wdata_o == exp_d) else report_mismatch("mem_wdata", exp_d, mem_wdata_o);
        end
      end
      if (rsp_valid_o) begin
        assert (pending) else report_error("response with no instruction in flight");
        assert (rsp_id_o == exp_id) else report_mismatch("rsp_id", 32'(exp_id), 32'(rsp_id_o));
        assert (exp_addr_q.size() == 0)
          else report_error("response before all memory requests were issued");
        pending   = 1'b0;
        rsp_count = rsp_count + 1;
      end else if (pending) begin
        assert (!req_ready_o) else report_error("req_ready_o high while instruction in flight");
      end
      // Prediction from the fields actually accepted
      if (req_valid_i && req_ready_o) begin
        pending = 1'b1;
        exp_id  = req_id_i;
        predict(req_op_i, req_vd_i, req_addr_i, int'(req_vl_i));
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  logic [ID_W-1:0] next_id;

  task automatic run_instr(input vlsu_op_e op, input logic [2:0] vd,
                           input logic [31:0] addr, input logic [2:0] vl);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_id_i    <= next_id;
    req_vd_i    <= vd;
    req_addr_i  <= addr;
    req_vl_i    <= vl;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    req_valid_i <= 1'b0;
    next_id = next_id + 1'b1;
    @(posedge clk_i);
    while (!rsp_valid_o) @(posedge clk_i);
  endtask

  initial begin : watchdog_proc
    repeat (200 * N_INSTR + 10) @(posedge clk_i);
    report_error("watchdog expired before all instructions completed");
  end

  initial begin : main_proc
    logic [2:0]  vd;
    logic [2:0]  vl;
    logic [31:0] src;
    void'($urandom(SEED));
    rst_i              = 1'b1;
    req_valid_i        = 1'b0;
    req_op_i           = VLE;
    req_id_i           = '0;
    req_vd_i           = '0;
    req_addr_i         = '0;
    req_vl_i           = 3'd1;
    mem_ready_i        = 1'b0;
    mem_result_valid_i = 1'b0;
    mem_rdata_i        = '0;
    next_id            = 4'd3;
    test_name          = "reset";
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int e = 0; e < NR_ELEMS; e++) begin
        exp_vrf[r][e] = 32'h0;
      end
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    assert (req_ready_o === 1'b1) else report_mismatch("req_ready", 32'd1, 32'(req_ready_o));
    assert (mem_valid_o === 1'b0) else report_mismatch("mem_valid", 32'd0, 32'(mem_valid_o));
    assert (rsp_valid_o === 1'b0) else report_mismatch("rsp_valid", 32'd0, 32'(rsp_valid_o));

    // Region A to region B through v1
    test_name = "copy";
    run_instr(VLE, 3'd1, 32'h0000_1000, 3'd4);
    run_instr(VSE, 3'd1, 32'h0000_2000, 3'd4);

    // Short loads followed by a full store of the same register
    test_name = "partial_load";
    for (int r = 0; r < N_ROUNDS; r++) begin
      vd  = 3'($urandom % NR_VREGS);
      vl  = 3'(($urandom % NR_ELEMS) + 1);
      src = 32'h0001_0000 + 32'(($urandom % 256) * 16);
      run_instr(VLE, vd, src, vl);
      run_instr(VSE, vd, 32'h0002_0000 + 32'(r * 16), 3'(NR_ELEMS));
    end

    test_name = "final_memory";
    repeat (10) @(posedge clk_i);
    foreach (ref_mem[a]) begin
      assert (model_word(a) == ref_mem[a])
        else report_mismatch("mem_word", ref_mem[a], model_word(a));
    end
    foreach (model_mem[a]) begin
      assert (ref_mem.exists(a)) else report_error("memory written at an unexpected address");
    end
    assert (rsp_count == N_INSTR) else report_mismatch("rsp_count", 32'(N_INSTR), 32'(rsp_count));
    $display("TB PASSED");
    $finish;
  end

endmodule

/* vlsu_top.sv */
/*
 * Vector load/store subsystem top level
 * Controller and vector register file
 */

`timescale 1ns/1ps

module vlsu_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Core request
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  vlsu_pkg::vlsu_op_e           req_op_i,
  input  logic [vlsu_pkg::ID_W-1:0]    req_id_i,
  input  logic [vlsu_pkg::VREG_AW-1:0] req_vd_i,
  input  logic [vlsu_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic [vlsu_pkg::VL_W-1:0]    req_vl_i,
  // Core response
  output logic                         rsp_valid_o,
  output logic [vlsu_pkg::ID_W-1:0]    rsp_id_o,
  // Memory request
  output logic                         mem_valid_o,
  input  logic                         mem_ready_i,
  output logic [vlsu_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic                         mem_we_o,
  output logic [vlsu_pkg::ELEM_W-1:0]  mem_wdata_o,
  // Memory result
  input  logic                         mem_result_valid_i,
  input  logic [vlsu_pkg::ELEM_W-1:0]  mem_rdata_i
);

  import vlsu_pkg::*;

  // Register file ports
  logic               vrf_we;
  logic [VREG_AW-1:0] vrf_wreg;
  logic [ELEM_AW-1:0] vrf_welem;
  logic [ELEM_W-1:0]  vrf_wdata;
  logic               vrf_re;
  logic [VREG_AW-1:0] vrf_rreg;
  logic [ELEM_AW-1:0] vrf_relem;
  logic [ELEM_W-1:0]  vrf_rdata;

  vlsu u_vlsu (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .req_valid_i        (req_valid_i),
    .req_ready_o        (req_ready_o),
    .req_op_i           (req_op_i),
    .req_id_i           (req_id_i),
    .req_vd_i           (req_vd_i),
    .req_addr_i         (req_addr_i),
    .req_vl_i           (req_vl_i),
    .rsp_valid_o        (rsp_valid_o),
    .rsp_id_o           (rsp_id_o),
    .mem_valid_o        (mem_valid_o),
    .mem_ready_i        (mem_ready_i),
    .mem_addr_o         (mem_addr_o),
    .mem_we_o           (mem_we_o),
    .mem_wdata_o        (mem_wdata_o),
    .mem_result_valid_i (mem_result_valid_i),
    .mem_rdata_i        (mem_rdata_i),
    .vrf_we_o           (vrf_we),
    .vrf_wreg_o         (vrf_wreg),
    .vrf_welem_o        (vrf_welem),
    .vrf_wdata_o        (vrf_wdata),
    .vrf_re_o           (vrf_re),
    .vrf_rreg_o         (vrf_rreg),
    .vrf_relem_o        (vrf_relem),
    .vrf_rdata_i        (vrf_rdata)
  );

  vreg_file u_vrf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .we_i    (vrf_we),
    .wreg_i  (vrf_wreg),
    .welem_i (vrf_welem),
    .wdata_i (vrf_wdata),
    .re_i    (vrf_re),
    .rreg_i  (vrf_rreg),
    .relem_i (vrf_relem),
    .rdata_o (vrf_rdata)
  );

endmodule

/* vlsu.sv */
/*
 * Vector load/store controller for unit-stride VLE and VSE
 * Element address generation, memory issue, outstanding count,
 * load writeback through the result queue, completion response
 */

`timescale 1ns/1ps

module vlsu (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Core request
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  vlsu_pkg::vlsu_op_e           req_op_i,
  input  logic [vlsu_pkg::ID_W-1:0]    req_id_i,
  input  logic [vlsu_pkg::VREG_AW-1:0] req_vd_i,
  input  logic [vlsu_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic [vlsu_pkg::VL_W-1:0]    req_vl_i,
  // Core response
  output logic                         rsp_valid_o,
  output logic [vlsu_pkg::ID_W-1:0]    rsp_id_o,
  // Memory request
  output logic                         mem_valid_o,
  input  logic                         mem_ready_i,
  output logic [vlsu_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic                         mem_we_o,
  output logic [vlsu_pkg::ELEM_W-1:0]  mem_wdata_o,
  // Memory result
  input  logic                         mem_result_valid_i,
  input  logic [vlsu_pkg::ELEM_W-1:0]  mem_rdata_i,
  // Register file
  output logic                         vrf_we_o,
  output logic [vlsu_pkg::VREG_AW-1:0] vrf_wreg_o,
  output logic [vlsu_pkg::ELEM_AW-1:0] vrf_welem_o,
  output logic [vlsu_pkg::ELEM_W-1:0]  vrf_wdata_o,
  output logic                         vrf_re_o,
  output logic [vlsu_pkg::VREG_AW-1:0] vrf_rreg_o,
  output logic [vlsu_pkg::ELEM_AW-1:0] vrf_relem_o,
  input  logic [vlsu_pkg::ELEM_W-1:0]  vrf_rdata_i
);

  import vlsu_pkg::*;

  vlsu_state_e                   state_q, state_d;
  // Captured instruction
  vlsu_op_e                      op_q;
  logic [ID_W-1:0]               id_q;
  logic [VREG_AW-1:0]            vd_q;
  logic [ADDR_W-1:0]             addr_q;
  logic [VL_W-1:0]               vl_q;
  // Progress counters
  logic [VL_W-1:0]               issue_cnt_q;
  logic [VL_W-1:0]               wb_cnt_q;
  logic [$clog2(RESULT_DEPTH):0] outst_q;
  logic                          rsp_valid_q;

  logic                          req_fire;
  logic                          mem_fire;
  logic                          issue_left;
  logic                          last_wb;
  logic                          store_done;
  logic                          fifo_push;
  logic                          fifo_pop;
  logic                          fifo_empty;
  logic                          fifo_full;
  logic [ELEM_W-1:0]             fifo_data;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign req_ready_o = (state_q == IDLE);
  assign req_fire    = req_valid_i && req_ready_o;
  assign mem_fire    = mem_valid_o && mem_ready_i;

  assign issue_left = (issue_cnt_q != vl_q);
  assign last_wb    = fifo_pop && (wb_cnt_q == vl_q - 1'b1);
  // All stores sent and every result returned
  assign store_done = !issue_left && (outst_q == '0);

  //////////////////////////////////////////////////
  // Memory request
  //////////////////////////////////////////////////

  // Loads stop issuing once the queue could be filled by reads in flight
  assign mem_valid_o = ((state_q == LOAD) && issue_left && (outst_q < RESULT_DEPTH)) ||
                       ((state_q == STORE_WR) && issue_left);
  assign mem_addr_o  = addr_q + {{(ADDR_W-VL_W-2){1'b0}}, issue_cnt_q, 2'b00};
  assign mem_we_o    = (op_q == VSE);
  // Read data holds until the next element read
  assign mem_wdata_o = vrf_rdata_i;

  //////////////////////////////////////////////////
  // Load writeback
  //////////////////////////////////////////////////

  assign fifo_push = mem_result_valid_i && (state_q == LOAD);
  assign fifo_pop  = !fifo_empty && (state_q == LOAD);

  result_fifo u_result_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .data_i  (mem_rdata_i),
    .pop_i   (fifo_pop),
    .data_o  (fifo_data),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  assign vrf_we_o    = fifo_pop;
  assign vrf_wreg_o  = vd_q;
  assign vrf_welem_o = wb_cnt_q[ELEM_AW-1:0];
  assign vrf_wdata_o = fifo_data;

  // Store element fetch
  assign vrf_re_o    = (state_q == STORE_RD);
  assign vrf_rreg_o  = vd_q;
  assign vrf_relem_o = issue_cnt_q[ELEM_AW-1:0];

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = id_q;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin : proc_next_state
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_fire) begin
          state_d = (req_op_i == VLE) ? LOAD : STORE_RD;
        end
      end
      LOAD: begin
        if (last_wb) begin
          state_d = IDLE;
        end
      end
      STORE_RD: state_d = STORE_WR;
      STORE_WR: begin
        if (mem_fire && (issue_cnt_q + 1'b1 != vl_q)) begin
          state_d = STORE_RD;
        end else if (store_done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin : proc_ctrl
    if (rst_i) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      wb_cnt_q    <= '0;
      outst_q     <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= ((state_q == LOAD) && last_wb) ||
                     ((state_q == STORE_WR) && store_done);
      if (req_fire) begin
        issue_cnt_q <= '0;
        wb_cnt_q    <= '0;
      end else begin
        if (mem_fire) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
        end
        if (fifo_pop) begin
          wb_cnt_q <= wb_cnt_q + 1'b1;
        end
      end
      case ({mem_fire, mem_result_valid_i})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;
      endcase
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin : proc_capture
    if (req_fire) begin
      op_q   <= req_op_i;
      id_q   <= req_id_i;
      vd_q   <= req_vd_i;
      addr_q <= req_addr_i;
      vl_q   <= req_vl_i;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Outstanding cap keeps the queue from overflowing
  a_no_push_full : assert property (@(posedge clk_i) disable iff (rst_i)
    !(fifo_push && fifo_full));

  a_mem_req_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=>
      mem_valid_o && $stable(mem_addr_o) && $stable(mem_wdata_o));

  // Memory returns nothing it was not asked for
  a_result_expected : assert property (@(posedge clk_i) disable iff (rst_i)
    mem_result_valid_i |-> (outst_q != '0));

endmodule

/* result_fifo.sv */
/*
 * Fall-through queue for memory read results
 * Circular buffer of RESULT_DEPTH entries
 */

`timescale 1ns/1ps

module result_fifo (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       push_i,
  input  logic [vlsu_pkg::ELEM_W-1:0] data_i,
  input  logic                       pop_i,
  output logic [vlsu_pkg::ELEM_W-1:0] data_o,
  output logic                       empty_o,
  output logic                       full_o
);

  import vlsu_pkg::*;

  logic [ELEM_W-1:0]               mem_q [RESULT_DEPTH];
  logic [$clog2(RESULT_DEPTH)-1:0] wptr_q;
  logic [$clog2(RESULT_DEPTH)-1:0] rptr_q;
  logic [$clog2(RESULT_DEPTH):0]   cnt_q;
  logic                            store_empty;
  logic                            do_push;
  logic                            do_pop;

  assign store_empty = (cnt_q == '0);
  assign full_o      = (cnt_q == RESULT_DEPTH);

  // An incoming value is visible at once when nothing is stored
  assign empty_o = store_empty && !push_i;
  assign data_o  = store_empty ? data_i : mem_q[rptr_q];

  // Value popped in its push cycle bypasses the storage
  assign do_push = push_i && !full_o && !(store_empty && pop_i);
  assign do_pop  = pop_i && !store_empty;

  always_ff @(posedge clk_i) begin : proc_ctrl
    if (rst_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : proc_store
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  // Consumer must only take an entry that exists
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

/* vreg_file.sv */
/*
 * Vector register file of 8 registers with 4 x 32-bit elements
 * One element write port, one registered element read port
 */

`timescale 1ns/1ps

module vreg_file (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Element write port
  input  logic                        we_i,
  input  logic [vlsu_pkg::VREG_AW-1:0] wreg_i,
  input  logic [vlsu_pkg::ELEM_AW-1:0] welem_i,
  input  logic [vlsu_pkg::ELEM_W-1:0]  wdata_i,
  // Element read port
  input  logic                        re_i,
  input  logic [vlsu_pkg::VREG_AW-1:0] rreg_i,
  input  logic [vlsu_pkg::ELEM_AW-1:0] relem_i,
  output logic [vlsu_pkg::ELEM_W-1:0]  rdata_o
);

  import vlsu_pkg::*;

  // Element storage
  logic [ELEM_W-1:0] regs_q [NR_VREGS][NR_ELEMS];

  //////////////////////////////////////////////////
  // Write
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : proc_write
    if (rst_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int e = 0; e < NR_ELEMS; e++) begin
          regs_q[r][e] <= '0;
        end
      end
    end else if (we_i) begin
      regs_q[wreg_i][welem_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////

  // Data appears one cycle after re_i and holds until the next read
  always_ff @(posedge clk_i) begin : proc_read
    if (rst_i) begin
      rdata_o <= '0;
    end else if (re_i) begin
      rdata_o <= regs_q[rreg_i][relem_i];
    end
  end

endmodule

/* vlsu_pkg.sv */
/*
 * Shared sizes of the vector load/store subsystem
 * Opcode and controller state encodings
 */

package vlsu_pkg;

  //////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////

  // Architectural vector registers
  localparam int unsigned NR_VREGS = 8;
  localparam int unsigned VREG_AW  = 3;

  // Elements held by one vector register
  localparam int unsigned NR_ELEMS = 4;
  localparam int unsigned ELEM_AW  = 2;
  localparam int unsigned ELEM_W   = 32;

  // Vector length field holding 1 to NR_ELEMS
  localparam int unsigned VL_W = 3;

  //////////////////////////////////////////////////
  // Core and memory side
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned ID_W   = 4;

  // Result queue depth and cap on reads in flight
  localparam int unsigned RESULT_DEPTH = 4;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Unit-stride load and store
  typedef enum logic {
    VLE = 1'b0,
    VSE = 1'b1
  } vlsu_op_e;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    LOAD     = 2'd1,
    STORE_RD = 2'd2,
    STORE_WR = 2'd3
  } vlsu_state_e;

endpackage
